//--- credit_pkg.sv
// ------------------
// Shared constants for the credit link
// Payload word type carried by a flit
// ------------------

package credit_pkg;

  // Width of one payload word
  localparam int DATA_WIDTH = 16;

  // Receiver buffer entries
  // Also the largest credit pool on either end
  localparam int BUF_DEPTH = 8;

  // Most credits handed back in one return strobe
  localparam int CRED_RET_MAX = 2;

  // Holds 0 to BUF_DEPTH
  localparam int CRED_WIDTH = $clog2(BUF_DEPTH + 1);

  // Holds 0 to CRED_RET_MAX
  localparam int CHG_WIDTH = $clog2(CRED_RET_MAX + 1);

  // Buffer pointer width
  localparam int PTR_WIDTH = $clog2(BUF_DEPTH);

  // One payload word
  typedef logic [DATA_WIDTH-1:0] flit_t;

endpackage : credit_pkg

//--- credit_link_if.sv
// ------------------
// Link between sender and receiver
// Flit strobe with payload going forward
// Credit strobe with count coming back
// ------------------

interface credit_link_if;
  import credit_pkg::*;

  // Forward direction
  // One-cycle strobe per flit
  logic     flit_valid;
  // Only meaningful while flit_valid is high
  flit_t    flit_data;

  // Return direction
  // One-cycle strobe per credit batch
  logic                 cred_valid;
  // 1 to CRED_RET_MAX while cred_valid is high
  logic [CHG_WIDTH-1:0] cred_count;

  // Sender end
  modport tx (
    output flit_valid,
    output flit_data,
    input  cred_valid,
    input  cred_count
  );

  // Receiver end
  modport rx (
    input  flit_valid,
    input  flit_data,
    output cred_valid,
    output cred_count
  );

endinterface : credit_link_if

//--- credit_counter.sv
// ------------------
// Generic credit pool
// Increment and decrement in the same cycle
// Decrement guard against underflow
// Reset value from a port and withholding
// ------------------

module credit_counter #(
  // Largest value the pool ever holds
  parameter int MAX_VALUE  = credit_pkg::BUF_DEPTH,
  // Largest single increment or decrement
  parameter int MAX_CHANGE = credit_pkg::CRED_RET_MAX,
  localparam int VALUE_WIDTH  = $clog2(MAX_VALUE + 1),
  localparam int CHANGE_WIDTH = $clog2(MAX_CHANGE + 1)
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Credits coming into the pool
  input  logic                    incr_valid,
  input  logic [CHANGE_WIDTH-1:0] incr,
  // Credits taken from the pool
  input  logic                    decr_valid,
  input  logic [CHANGE_WIDTH-1:0] decr,
  output logic                    decr_ready,
  // Loaded while in reset
  input  logic [VALUE_WIDTH-1:0]  init_value,
  // Part of the pool kept out of circulation
  input  logic [VALUE_WIDTH-1:0]  withhold,
  // Stored credit count
  output logic [VALUE_WIDTH-1:0]  value,
  // Usable credit this cycle
  output logic [VALUE_WIDTH-1:0]  available
);

  logic [VALUE_WIDTH-1:0] incr_amt;
  logic [VALUE_WIDTH-1:0] decr_amt;
  logic [VALUE_WIDTH-1:0] value_plus_incr;
  logic [VALUE_WIDTH-1:0] value_next;
  logic                   value_en;

  // --------------------
  // Change amounts
  // --------------------

  // Zero when the strobe is low
  assign incr_amt = incr_valid ? VALUE_WIDTH'(incr) : '0;
  assign decr_amt = (decr_valid && decr_ready) ? VALUE_WIDTH'(decr) : '0;

  // Incoming credit is usable in the same cycle
  assign value_plus_incr = value + incr_amt;

  // Saturate at zero when withhold exceeds the pool
  assign available = (value_plus_incr > withhold) ? (value_plus_incr - withhold) : '0;

  // Guard looks at the amount only so it never loops through decr_valid
  assign decr_ready = (VALUE_WIDTH'(decr) <= available);

  // --------------------
  // Pool register
  // --------------------

  assign value_next = value_plus_incr - decr_amt;
  assign value_en   = incr_valid || (decr_valid && decr_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= init_value;
    end else if (value_en) begin
      value <= value_next;
    end
  end

endmodule : credit_counter

//--- credit_sender.sv
// ------------------
// Sending end of the credit link
// Upstream valid/ready port
// Sender credit pool and flit launch register
// ------------------

module credit_sender (
  input  logic                                clk,
  input  logic                                rst_n,
  // Upstream port
  input  logic                                in_valid,
  input  credit_pkg::flit_t                   in_data,
  output logic                                in_ready,
  // Pool configuration
  input  logic [credit_pkg::CRED_WIDTH-1:0]   init_credits,
  input  logic [credit_pkg::CRED_WIDTH-1:0]   withhold,
  // Usable credit for status
  output logic [credit_pkg::CRED_WIDTH-1:0]   credits_available,
  // Link toward the receiver
  credit_link_if.tx                           link
);
  import credit_pkg::*;

  logic                  decr_ready;
  logic                  in_accept;

  // --------------------
  // Credit pool
  // --------------------

  // Returned batches increment and each accepted word costs one credit
  credit_counter #(
    .MAX_VALUE  (BUF_DEPTH),
    .MAX_CHANGE (CRED_RET_MAX)
  ) u_tx_credits (
    .clk        (clk),
    .rst_n      (rst_n),
    .incr_valid (link.cred_valid),
    .incr       (link.cred_count),
    .decr_valid (in_valid),
    .decr       (CHG_WIDTH'(1)),
    .decr_ready (decr_ready),
    .init_value (init_credits),
    .withhold   (withhold),
    .value      (),
    .available  (credits_available)
  );

  // Ready whenever one credit is usable
  assign in_ready  = decr_ready;
  assign in_accept = in_valid && in_ready;

  // --------------------
  // Flit launch
  // --------------------

  // Strobe goes out the cycle after acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link.flit_valid <= 1'b0;
    end else begin
      link.flit_valid <= in_accept;
    end
  end

  // Payload only loads on an accepted word
  always_ff @(posedge clk) begin
    if (in_accept) begin
      link.flit_data <= in_data;
    end
  end

endmodule : credit_sender

//--- credit_receiver.sv
// ------------------
// Receiving end of the credit link
// Circular flit buffer and downstream port
// Batched credit return from a receiver pool
// ------------------

module credit_receiver (
  input  logic              clk,
  input  logic              rst_n,
  // Link from the sender
  credit_link_if.rx         link,
  // Downstream port
  output logic              out_valid,
  output credit_pkg::flit_t out_data,
  input  logic              out_ready
);
  import credit_pkg::*;

  // Flit storage
  flit_t                 mem [BUF_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CRED_WIDTH-1:0] count;

  logic                  push;
  logic                  pop;

  // Return pool
  logic [CRED_WIDTH-1:0] ret_pool;
  logic                  ret_valid;
  logic [CHG_WIDTH-1:0]  ret_amt;
  logic                  ret_ready;

  // --------------------
  // Flit buffer
  // --------------------

  // Sender only launches with a credit so no full check here
  assign push = link.flit_valid;
  assign pop  = out_valid && out_ready;

  // Oldest entry is shown downstream
  // Held steady while stalled since rd_ptr does not move
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= link.flit_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at the last entry
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------
  // Credit return
  // --------------------

  // Batch is sized from the stored pool
  // so a pop shows up in the pool one cycle later
  assign ret_valid = (ret_pool != '0);
  assign ret_amt   = (ret_pool > CRED_WIDTH'(CRED_RET_MAX)) ?
                     CHG_WIDTH'(CRED_RET_MAX) : CHG_WIDTH'(ret_pool);

  // Every pop frees one entry and earns one credit
  credit_counter #(
    .MAX_VALUE  (BUF_DEPTH),
    .MAX_CHANGE (CRED_RET_MAX)
  ) u_rx_credits (
    .clk        (clk),
    .rst_n      (rst_n),
    .incr_valid (pop),
    .incr       (CHG_WIDTH'(1)),
    .decr_valid (ret_valid),
    .decr       (ret_amt),
    .decr_ready (ret_ready),
    .init_value ('0),
    .withhold   ('0),
    .value      (ret_pool),
    .available  ()
  );

  // Registered return strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      link.cred_valid <= 1'b0;
    end else begin
      link.cred_valid <= ret_valid && ret_ready;
    end
  end

  // Count only matters alongside the strobe
  always_ff @(posedge clk) begin
    if (ret_valid) begin
      link.cred_count <= ret_amt;
    end
  end

endmodule : credit_receiver

//--- credit_link_top.sv
// ------------------
// Top level of the credit link
// Sender and receiver joined by the link interface
// ------------------

module credit_link_top (
  input  logic                              clk,
  input  logic                              rst_n,
  // Upstream port
  input  logic                              in_valid,
  input  credit_pkg::flit_t                 in_data,
  output logic                              in_ready,
  // Downstream port
  output logic                              out_valid,
  output credit_pkg::flit_t                 out_data,
  input  logic                              out_ready,
  // Sender pool configuration
  input  logic [credit_pkg::CRED_WIDTH-1:0] init_credits,
  input  logic [credit_pkg::CRED_WIDTH-1:0] withhold,
  // Sender usable credit
  output logic [credit_pkg::CRED_WIDTH-1:0] credits_available
);

  // --------------------
  // Link between ends
  // --------------------

  credit_link_if u_link ();

  // Sending end
  credit_sender u_sender (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid          (in_valid),
    .in_data           (in_data),
    .in_ready          (in_ready),
    .init_credits      (init_credits),
    .withhold          (withhold),
    .credits_available (credits_available),
    .link              (u_link)
  );

  // Receiving end
  credit_receiver u_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .link      (u_link),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

endmodule : credit_link_top

//--- tb_credit_link.sv
// ------------------
// Testbench for the credit link top level
// Clock, reset and a table of test rows
// Scoreboard queue with compare tasks
// Watchdog and closing summary
// ------------------

module tb_credit_link;
  timeunit 1ns;
  timeprecision 100ps;
  import credit_pkg::*;

  typedef logic [CRED_WIDTH-1:0] cred_t;

  // How out_ready behaves during a row
  typedef enum logic [1:0] {MODE_READY, MODE_BLOCK, MODE_RANDOM} stall_t;

  // One test row
  typedef struct packed {
    cred_t      init;
    cred_t      hold;
    logic [7:0] words;
    stall_t     mode;
  } row_t;

  localparam int NUM_ROWS = 8;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  in_valid;
  flit_t in_data;
  logic  in_ready;
  logic  out_valid;
  flit_t out_data;
  logic  out_ready;
  cred_t init_credits;
  cred_t withhold;
  cred_t credits_available;

  row_t   rows [NUM_ROWS];
  flit_t  sb_queue [$];
  integer seed = 32'hc8f6;
  int     errors;
  int     tests_passed;
  int     tests_failed;
  // Per-row progress
  int     sent;
  int     received;
  int     idle_cycles;
  int     cur_limit;
  // Outputs seen at the last falling edge
  cred_t  avail_seen;
  logic   ready_seen;

  credit_link_top u_credit_link_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .in_valid          (in_valid),
    .in_data           (in_data),
    .in_ready          (in_ready),
    .out_valid         (out_valid),
    .out_data          (out_data),
    .out_ready         (out_ready),
    .init_credits      (init_credits),
    .withhold          (withhold),
    .credits_available (credits_available)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_credit(input string name, input cred_t got, input cred_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // init, withhold, words, out_ready behavior
  task automatic fill_table();
    rows[0] = '{cred_t'(8), cred_t'(0), 8'd20, MODE_READY};
    rows[1] = '{cred_t'(8), cred_t'(0), 8'd24, MODE_BLOCK};
    rows[2] = '{cred_t'(8), cred_t'(3), 8'd24, MODE_BLOCK};
    rows[3] = '{cred_t'(6), cred_t'(2), 8'd30, MODE_RANDOM};
    rows[4] = '{cred_t'(8), cred_t'(5), 8'd30, MODE_RANDOM};
    rows[5] = '{cred_t'(3), cred_t'(0), 8'd12, MODE_RANDOM};
    // Withhold above the pool so nothing may flow
    rows[6] = '{cred_t'(2), cred_t'(5), 8'd0, MODE_READY};
    rows[7] = '{cred_t'(4), cred_t'(0), 8'd2, MODE_BLOCK};
  endtask

  // Configuration held stable while rst_n is low
  task automatic apply_reset(input cred_t init, input cred_t hold);
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    init_credits = init;
    withhold     = hold;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  // Sample at the falling edge, where every output has settled
  // then move on to 1 ns after the next rising edge
  task automatic step_cycle();
    flit_t exp_word;
    @(negedge clk);
    avail_seen = credits_available;
    ready_seen = in_ready;
    if (in_valid && in_ready) begin
      sb_queue.push_back(in_data);
      sent++;
    end
    if (out_valid && out_ready) begin
      if (sb_queue.size() == 0) begin
        $display("Word 0x%h left the link with nothing outstanding", out_data);
        errors++;
      end else begin
        exp_word = sb_queue.pop_front();
        check_flit("out_data", out_data, exp_word);
      end
      received++;
      idle_cycles = 0;
    end else if (out_ready) begin
      idle_cycles++;
    end
    // Words in flight or buffered are bounded by the usable pool
    if (sent - received > cur_limit) begin
      $display("%0d words outstanding, more than the %0d credits", sent - received, cur_limit);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // --------------------
  // One table row
  // --------------------

  task automatic run_row(input int r);
    row_t row;
    int   err_start;
    int   low_cycles;
    int   wait_cycles;
    int   exp_accept;
    bit   blocked;
    logic exp_ready;
    row        = rows[r];
    err_start  = errors;
    cur_limit  = (row.init > row.hold) ? int'(row.init - row.hold) : 0;
    exp_accept = (int'(row.words) < cur_limit) ? int'(row.words) : cur_limit;
    exp_ready  = (cur_limit != 0);
    apply_reset(row.init, row.hold);
    sent        = 0;
    received    = 0;
    idle_cycles = 0;
    sb_queue.delete();
    // Buffer comes out of reset empty
    if (out_valid !== 1'b0) begin
      $display("mismatch out_valid: got 0x%h expected 0x%h", out_valid, 1'b0);
      errors++;
    end
    step_cycle();
    check_credit("credits_available", avail_seen, cred_t'(cur_limit));
    if (ready_seen !== exp_ready) begin
      $display("mismatch in_ready: got 0x%h expected 0x%h", ready_seen, exp_ready);
      errors++;
    end
    blocked    = (row.mode == MODE_BLOCK);
    low_cycles = 0;
    // Stop on full delivery or when the output has gone quiet too long
    while (received < int'(row.words) && idle_cycles < 64) begin
      in_valid = (sent < int'(row.words));
      // Counter plus row index
      in_data  = flit_t'((sent << 8) + r);
      case (row.mode)
        MODE_READY: out_ready = 1'b1;
        MODE_BLOCK: out_ready = !blocked;
        default:    out_ready = (($random(seed) & 1) != 0);
      endcase
      step_cycle();
      if (blocked) begin
        low_cycles = ready_seen ? 0 : low_cycles + 1;
        if (low_cycles >= 8 || sent == int'(row.words)) begin
          blocked = 1'b0;
          check_credit("words_accepted", cred_t'((sent > 15) ? 15 : sent),
                       cred_t'(exp_accept));
        end
      end
    end
    if (received < int'(row.words)) begin
      $display("Word %0d of %0d never arrived at the output", received, row.words);
      errors++;
    end
    // Idle drain, every credit should find its way home
    in_valid    = 1'b0;
    out_ready   = 1'b1;
    wait_cycles = 0;
    step_cycle();
    while (avail_seen != cred_t'(cur_limit) && wait_cycles < 32) begin
      step_cycle();
      wait_cycles++;
    end
    check_credit("credits_available", avail_seen, cred_t'(cur_limit));
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %0d ok: init %0d withhold %0d words %0d", r, row.init, row.hold, row.words);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", r, errors - err_start);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int r;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    init_credits = '0;
    withhold     = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_limit    = 0;
    fill_table();
    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget of 200 cycles per row plus 20 per word
  initial begin
    int limit;
    int r;
    #1;
    limit = 0;
    for (r = 0; r < NUM_ROWS; r++) begin
      limit += 200 + 20 * int'(rows[r].words);
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tb_credit_link

//--- all.f
credit_pkg.sv
credit_link_if.sv
credit_counter.sv
credit_sender.sv
credit_receiver.sv
credit_link_top.sv
tb_credit_link.sv
